// File: Bender.yml
package:
  name: mem_system

sources:
  # packages first, then the blocks, then the top level
  - verilog/cacheGeometryPkg.sv
  - verilog/memCtrlPkg.sv
  - verilog/cacheWay.sv
  - verilog/wayPolicy.sv
  - verilog/bankedMemory.sv
  - verilog/missController.sv
  - verilog/memSystem.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/memSystemTb.sv

// File: memSystem.f
verilog/cacheGeometryPkg.sv
verilog/memCtrlPkg.sv
verilog/cacheWay.sv
verilog/wayPolicy.sv
verilog/bankedMemory.sv
verilog/missController.sv
verilog/memSystem.sv
tests/tbClock.sv
tests/memSystemTb.sv

// File: tests/memSystemTb.sv
// memSystem testbench: replays an access trace against the cache and checks every response
`timescale 1ns/1ns
`default_nettype none

module memSystemTb;

   localparam int clkPeriodNs   = 20;
   // per-line cycle budget well above the longest miss with eviction
   localparam int cyclesPerLine = 40;
   localparam int setupCycles   = 10;
   // request seen in idle, compare, then done
   localparam int hitCycles     = 2;

   logic                   clk;
   logic                   rstN;
   cacheGeometryPkg::addrT addr;
   cacheGeometryPkg::wordT dataIn;
   logic                   rd;
   logic                   wr;
   cacheGeometryPkg::wordT dataOut;
   logic                   done;
   logic                   stall;
   logic                   cacheHit;

   // one entry per trace line
   logic                   traceWrite [$];
   cacheGeometryPkg::addrT traceAddr  [$];
   cacheGeometryPkg::wordT traceData  [$];
   cacheGeometryPkg::wordT traceRead  [$];
   logic                   traceHit   [$];
   logic                   traceReady;

   tbClock #(.periodNs(clkPeriodNs), .resetCycles(2)) u_tbClock (
      .clk  (clk),
      .rstN (rstN)
   );

   memSystem u_memSystem (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (addr),
      .dataIn   (dataIn),
      .rd       (rd),
      .wr       (wr),
      .dataOut  (dataOut),
      .done     (done),
      .stall    (stall),
      .cacheHit (cacheHit)
   );

   // ##############################
   // reporting
   // ##############################
   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
      if (actual !== expected) begin
         stopWithFailure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                   $time, name, actual, expected));
      end
   endtask

   // ##############################
   // trace loading
   // ##############################

   // each line holds an op letter, then address, write data, read data and hit flag in hex
   task automatic loadTrace();
      int                     fd;
      int                     c;
      int                     fields;
      cacheGeometryPkg::addrT a;
      cacheGeometryPkg::wordT d;
      cacheGeometryPkg::wordT e;
      logic [3:0]             h;
      fd = $fopen("tests/memSystemTrace.txt", "r");
      if (fd == 0) begin
         stopWithFailure("could not open the trace file tests/memSystemTrace.txt");
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (c == "#") begin
            // comment runs to the end of the line
            while (c != "\n" && c != -1) begin
               c = $fgetc(fd);
            end
         end else if (c == "R" || c == "W") begin
            fields = $fscanf(fd, "%h %h %h %h", a, d, e, h);
            if (fields != 4) begin
               stopWithFailure("a trace line does not hold four values after its operation");
            end
            traceWrite.push_back(c == "W");
            traceAddr.push_back(a);
            traceData.push_back(d);
            traceRead.push_back(e);
            traceHit.push_back(h[0]);
         end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
            stopWithFailure($sformatf("the trace file has an unknown operation '%c'", c));
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
      if (traceAddr.size() == 0) begin
         stopWithFailure("the trace file holds no accesses");
      end
   endtask

   // ##############################
   // one access
   // ##############################

   // drive on the falling edge, hold until done, then one quiet cycle
   task automatic runAccess(input int n);
      int   waited;
      logic compareStall;
      waited       = 0;
      compareStall = 1'b0;
      addr         = traceAddr[n];
      dataIn       = traceData[n];
      rd           = ~traceWrite[n];
      wr           = traceWrite[n];
      do begin
         @(negedge clk);
         waited++;
         // first cycle after the request is the compare state
         if (waited == 1) begin
            compareStall = stall;
         end
      end while (done !== 1'b1);
      checkValue("cacheHit", cacheHit, traceHit[n]);
      checkValue("stall at done", stall, 1'b0);
      checkValue("stall in compare", compareStall, 1'b1);
      // read data only counts on reads
      if (!traceWrite[n]) begin
         checkValue("dataOut", dataOut, traceRead[n]);
      end
      if (traceHit[n]) begin
         checkValue("hit latency in cycles", waited, hitCycles);
      end
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
   endtask

   // ##############################
   // main sequence and watchdog
   // ##############################
   initial begin
      rd         = 1'b0;
      wr         = 1'b0;
      addr       = '0;
      dataIn     = '0;
      traceReady = 1'b0;
      loadTrace();
      traceReady = 1'b1;
      wait (rstN === 1'b1);
      @(posedge clk);
      @(negedge clk);
      // quiet after reset
      checkValue("done after reset", done, 1'b0);
      checkValue("cacheHit after reset", cacheHit, 1'b0);
      checkValue("stall after reset", stall, 1'b0);
      for (int i = 0; i < traceAddr.size(); i++) begin
         runAccess(i);
      end
      $display("Done: no errors");
      $finish;
   end

   initial begin : watchdog
      int limitCycles;
      wait (traceReady === 1'b1);
      limitCycles = cyclesPerLine * traceAddr.size() + setupCycles;
      repeat (limitCycles) @(posedge clk);
      stopWithFailure($sformatf("timeout: the trace did not finish within %0d clock cycles",
                                limitCycles));
   end

endmodule

`default_nettype wire

// File: tests/memSystemTrace.txt
# op R/W, byte address, write data, expected read data, expected hit (all hex)
# read data is only checked on R lines
R 0000 0000 0000 0
W 0084 1111 0000 0
R 0084 0000 1111 1
W 0900 A001 0000 0
R 0900 0000 A001 1
W 1102 B002 0000 0
R 1102 0000 B002 1
R 0900 0000 A001 1
R 1102 0000 B002 1
W 1906 C003 0000 0
R 1906 0000 C003 1
R 1102 0000 B002 0
R 0900 0000 A001 1
R 1906 0000 C003 0
R 1100 0000 0000 0
R 0900 0000 A001 0
W 2180 D000 0000 0
W 2182 D111 0000 1
W 2184 D222 0000 1
W 2186 D333 0000 1
W 2980 E000 0000 0
R 2980 0000 E000 1
W 3180 F000 0000 0
R 2182 0000 D111 0
R 2180 0000 D000 1
R 2184 0000 D222 1
R 2186 0000 D333 1
R 2187 0000 D333 1
R 2980 0000 E000 0
R 0084 0000 1111 1

// File: tests/tbClock.sv
// tbClock: free-running testbench clock and a power-on reset held for the first cycles
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
   parameter int periodNs    = 20,
   parameter int resetCycles = 2
) (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // release lands on a falling edge, half a cycle away from the DUT's clock edge
   initial begin
      rstN = 1'b0;
      #(resetCycles * periodNs);
      rstN = 1'b1;
   end

endmodule

`default_nettype wire

// File: verilog/bankedMemory.sv
// bankedMemory: four word-interleaved banks with fixed read latency and busy-bank stall
`timescale 1ns/1ns
`default_nettype none

module bankedMemory (
   input  wire logic                    clk,
   input  wire logic                    rstN,
   input  wire memCtrlPkg::memReqT      memReq,
   output cacheGeometryPkg::wordT       memData,
   output logic                         stall
);

   cacheGeometryPkg::wordT    bankMem  [cacheGeometryPkg::lineWords][memCtrlPkg::bankRows];
   memCtrlPkg::busyCountT     busyCnt  [cacheGeometryPkg::lineWords];
   // read data in flight, oldest at the end
   cacheGeometryPkg::wordT    readPipe [memCtrlPkg::readLatency];
   cacheGeometryPkg::wordSelT bankSel;
   memCtrlPkg::bankRowT       row;
   logic                      accept;

   // addr bits 2..1 pick the bank, bits 15..3 the row
   assign bankSel = memReq.addr[2:1];
   assign row     = memReq.addr[15:3];

   assign stall  = busyCnt[bankSel] != '0;
   assign accept = (memReq.rd | memReq.wr) & ~stall;

   // ############################
   // bank busy counters
   // ############################
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int b = 0; b < cacheGeometryPkg::lineWords; b++) begin
            busyCnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < cacheGeometryPkg::lineWords; b++) begin
            if (accept && bankSel == cacheGeometryPkg::wordSelT'(b)) begin
               busyCnt[b] <= memCtrlPkg::busyCountT'(memCtrlPkg::bankBusyCycles);
            end else if (busyCnt[b] != '0) begin
               busyCnt[b] <= busyCnt[b] - 1'b1;
            end
         end
      end
   end

   // bank contents, all zero out of reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int b = 0; b < cacheGeometryPkg::lineWords; b++) begin
            for (int r = 0; r < memCtrlPkg::bankRows; r++) begin
               bankMem[b][r] <= '0;
            end
         end
      end else if (accept && memReq.wr) begin
         bankMem[bankSel][row] <= memReq.data;
      end
   end

   // ############################
   // read pipeline
   // ############################
   always_ff @(posedge clk) begin
      readPipe[0] <= (accept && memReq.rd) ? bankMem[bankSel][row] : '0;
      for (int i = 1; i < memCtrlPkg::readLatency; i++) begin
         readPipe[i] <= readPipe[i-1];
      end
   end

   assign memData = readPipe[memCtrlPkg::readLatency-1];

endmodule

`default_nettype wire

// File: verilog/cacheGeometryPkg.sv
// cache geometry: address split, storage sizes and the command and status structs of a way
`default_nettype none

package cacheGeometryPkg;

   // ############################
   // address fields and data words
   // ############################
   typedef logic [4:0]  tagT;
   typedef logic [7:0]  indexT;
   typedef logic [2:0]  offsetT;
   typedef logic [15:0] wordT;
   typedef logic [15:0] addrT;

   // four 16-bit words per line, one per memory bank
   localparam int lineWords = 4;
   localparam int numSets   = 2 ** $bits(indexT);

   // word position inside a line, also the bank number
   typedef logic [$clog2(lineWords)-1:0] wordSelT;

   // byte address split into its cache fields
   typedef struct packed {
      tagT    tag;
      indexT  index;
      offsetT offset;
   } addrFieldsT;

   // ############################
   // controller to way, way to policy
   // ############################

   // command shared by both ways; write is gated per way afterwards
   typedef struct packed {
      logic   enable;
      logic   compare;
      logic   write;
      tagT    tag;
      indexT  index;
      offsetT offset;
      wordT   dataIn;
   } cacheCmdT;

   // what one way reports for the addressed set and word
   typedef struct packed {
      logic hit;
      logic valid;
      logic dirty;
      tagT  tagOut;
      wordT dataOut;
   } wayStatusT;

endpackage

`default_nettype wire

// File: verilog/cacheWay.sv
// cacheWay: one way of tag, valid, dirty and line storage with its tag compare
`timescale 1ns/1ns
`default_nettype none

module cacheWay (
   input  wire logic                       clk,
   input  wire logic                       rstN,
   input  wire cacheGeometryPkg::cacheCmdT cacheCmd,
   input  wire logic                       wayWrite,
   output cacheGeometryPkg::wayStatusT     wayStatus
);

   // storage, one entry per set
   cacheGeometryPkg::tagT  tagMem   [cacheGeometryPkg::numSets];
   logic                   validMem [cacheGeometryPkg::numSets];
   logic                   dirtyMem [cacheGeometryPkg::numSets];
   cacheGeometryPkg::wordT dataMem  [cacheGeometryPkg::numSets][cacheGeometryPkg::lineWords];

   cacheGeometryPkg::wordSelT wordSel;
   logic                      tagMatch;
   logic                      doWrite;
   logic                      hitWrite;
   logic                      fillWrite;

   // byte offset to word, bit 0 ignored
   assign wordSel  = cacheCmd.offset[2:1];
   assign tagMatch = tagMem[cacheCmd.index] == cacheCmd.tag;

   // write qualified by enable and by the policy's way choice
   assign doWrite   = cacheCmd.enable & cacheCmd.write & wayWrite;
   // compare write only lands on a hit, this covers the final write after a fill too
   assign hitWrite  = doWrite & cacheCmd.compare & wayStatus.hit;
   // line fill from memory
   assign fillWrite = doWrite & ~cacheCmd.compare;

   // status is combinational from the command
   always_comb begin
      wayStatus.valid   = validMem[cacheCmd.index];
      wayStatus.dirty   = validMem[cacheCmd.index] & dirtyMem[cacheCmd.index];
      wayStatus.hit     = cacheCmd.enable & validMem[cacheCmd.index] & tagMatch;
      wayStatus.tagOut  = tagMem[cacheCmd.index];
      wayStatus.dataOut = dataMem[cacheCmd.index][wordSel];
   end

   // valid and dirty state
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int s = 0; s < cacheGeometryPkg::numSets; s++) begin
            validMem[s] <= 1'b0;
            dirtyMem[s] <= 1'b0;
         end
      end else if (fillWrite) begin
         // fill brings a clean copy
         validMem[cacheCmd.index] <= 1'b1;
         dirtyMem[cacheCmd.index] <= 1'b0;
      end else if (hitWrite) begin
         dirtyMem[cacheCmd.index] <= 1'b1;
      end
   end

   // tags and line words
   always_ff @(posedge clk) begin
      if (fillWrite) begin
         tagMem[cacheCmd.index] <= cacheCmd.tag;
      end
      if (fillWrite | hitWrite) begin
         dataMem[cacheCmd.index][wordSel] <= cacheCmd.dataIn;
      end
   end

endmodule

`default_nettype wire

// File: verilog/memCtrlPkg.sv
// miss controller and memory definitions: FSM states, memory request and bank timing
`default_nettype none

package memCtrlPkg;

   // ############################
   // bank timing
   // ############################

   // cycles from an accepted read to data on memData
   localparam int readLatency    = 2;
   // cycles a bank stays busy after any accepted access
   localparam int bankBusyCycles = 4;

   typedef logic [$clog2(bankBusyCycles+1)-1:0] busyCountT;

   // row inside one bank, taken from addr bits 15..3
   typedef logic [$bits(cacheGeometryPkg::addrT)-4:0] bankRowT;
   localparam int bankRows = 2 ** $bits(bankRowT);

   // ############################
   // controller
   // ############################
   typedef enum logic [4:0] {
      idle,
      compRead,
      compWrite,
      evict0,
      evict1,
      evict2,
      evict3,
      fill0,
      fill1,
      fill2Write0,
      fill3Write1,
      write2,
      write3,
      finalWrite,
      writeDone,
      hitDone
   } ctrlStateT;

   // levels toward the banked memory, held while stall is high
   typedef struct packed {
      logic                   rd;
      logic                   wr;
      cacheGeometryPkg::addrT addr;
      cacheGeometryPkg::wordT data;
   } memReqT;

endpackage

`default_nettype wire

// File: verilog/memSystem.sv
// memSystem: 2-way write-back cache with miss controller in front of a four-bank memory
`timescale 1ns/1ns
`default_nettype none

module memSystem (
   input  wire logic                   clk,
   input  wire logic                   rstN,
   input  wire cacheGeometryPkg::addrT addr,
   input  wire cacheGeometryPkg::wordT dataIn,
   input  wire logic                   rd,
   input  wire logic                   wr,
   output cacheGeometryPkg::wordT      dataOut,
   output logic                        done,
   output logic                        stall,
   output logic                        cacheHit
);

   cacheGeometryPkg::cacheCmdT  cacheCmd;
   cacheGeometryPkg::wayStatusT way0Status;
   cacheGeometryPkg::wayStatusT way1Status;
   cacheGeometryPkg::tagT       victimTag;
   cacheGeometryPkg::wordT      memData;
   memCtrlPkg::memReqT          ctrlReq;
   memCtrlPkg::memReqT          memReq;
   logic wayWrite0;
   logic wayWrite1;
   logic lookupHit;
   logic victimDirty;
   logic updateSelect;
   logic flipVictim;
   logic memStall;

   // ############################
   // controller
   // ############################
   missController u_missController (
      .clk          (clk),
      .rstN         (rstN),
      .rd           (rd),
      .wr           (wr),
      .addr         (addr),
      .dataIn       (dataIn),
      .lookupHit    (lookupHit),
      .victimDirty  (victimDirty),
      .victimTag    (victimTag),
      .memData      (memData),
      .memStall     (memStall),
      .cacheCmd     (cacheCmd),
      .updateSelect (updateSelect),
      .flipVictim   (flipVictim),
      .memReq       (ctrlReq),
      .done         (done),
      .stall        (stall),
      .cacheHit     (cacheHit)
   );

   // ############################
   // ways and policy
   // ############################
   cacheWay way0 (
      .clk       (clk),
      .rstN      (rstN),
      .cacheCmd  (cacheCmd),
      .wayWrite  (wayWrite0),
      .wayStatus (way0Status)
   );

   cacheWay way1 (
      .clk       (clk),
      .rstN      (rstN),
      .cacheCmd  (cacheCmd),
      .wayWrite  (wayWrite1),
      .wayStatus (way1Status)
   );

   wayPolicy u_wayPolicy (
      .clk          (clk),
      .rstN         (rstN),
      .way0         (way0Status),
      .way1         (way1Status),
      .cmdWrite     (cacheCmd.write),
      .updateSelect (updateSelect),
      .flipVictim   (flipVictim),
      .wayWrite0    (wayWrite0),
      .wayWrite1    (wayWrite1),
      .lookupHit    (lookupHit),
      .victimDirty  (victimDirty),
      .victimTag    (victimTag),
      .dataOut      (dataOut)
   );

   // evicted words come straight from the selected way's read port
   assign memReq = '{rd: ctrlReq.rd, wr: ctrlReq.wr, addr: ctrlReq.addr, data: dataOut};

   bankedMemory u_bankedMemory (
      .clk     (clk),
      .rstN    (rstN),
      .memReq  (memReq),
      .memData (memData),
      .stall   (memStall)
   );

endmodule

`default_nettype wire

// File: verilog/missController.sv
// missController: FSM for lookups, dirty-line eviction, line fill and the delayed write
`timescale 1ns/1ns
`default_nettype none

module missController (
   input  wire logic                   clk,
   input  wire logic                   rstN,
   input  wire logic                   rd,
   input  wire logic                   wr,
   input  wire cacheGeometryPkg::addrT addr,
   input  wire cacheGeometryPkg::wordT dataIn,
   input  wire logic                   lookupHit,
   input  wire logic                   victimDirty,
   input  wire cacheGeometryPkg::tagT  victimTag,
   input  wire cacheGeometryPkg::wordT memData,
   input  wire logic                   memStall,
   output cacheGeometryPkg::cacheCmdT  cacheCmd,
   output logic                        updateSelect,
   output logic                        flipVictim,
   output memCtrlPkg::memReqT          memReq,
   output logic                        done,
   output logic                        stall,
   output logic                        cacheHit
);

   memCtrlPkg::ctrlStateT       state;
   memCtrlPkg::ctrlStateT       nextState;
   cacheGeometryPkg::addrFieldsT req;
   cacheGeometryPkg::wordSelT   memWord;
   cacheGeometryPkg::wordSelT   cacheWord;
   logic                        isEvict;
   logic                        isFillRead;
   logic                        isFillWrite;
   logic                        isReady;

   // a request counts only with exactly one of rd and wr
   function automatic memCtrlPkg::ctrlStateT startState(input logic rdReq, input logic wrReq);
      if (rdReq == wrReq) begin
         return memCtrlPkg::idle;
      end
      return rdReq ? memCtrlPkg::compRead : memCtrlPkg::compWrite;
   endfunction

   // word address of one line position
   function automatic cacheGeometryPkg::addrT wordAddr(input cacheGeometryPkg::tagT lineTag,
                                                       input cacheGeometryPkg::indexT lineIdx,
                                                       input cacheGeometryPkg::wordSelT word);
      return {lineTag, lineIdx, word, 1'b0};
   endfunction

   assign req = addr;

   // ############################
   // state register
   // ############################
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= memCtrlPkg::idle;
      end else begin
         state <= nextState;
      end
   end

   // state groups
   assign isEvict     = state inside {memCtrlPkg::evict0, memCtrlPkg::evict1,
                                      memCtrlPkg::evict2, memCtrlPkg::evict3};
   assign isFillRead  = state inside {memCtrlPkg::fill0, memCtrlPkg::fill1,
                                      memCtrlPkg::fill2Write0, memCtrlPkg::fill3Write1};
   // cache writes trail the bank reads by two states, matching readLatency
   assign isFillWrite = state inside {memCtrlPkg::fill2Write0, memCtrlPkg::fill3Write1,
                                      memCtrlPkg::write2, memCtrlPkg::write3};
   assign isReady     = state inside {memCtrlPkg::idle, memCtrlPkg::hitDone,
                                      memCtrlPkg::writeDone};

   // word positions per state, memory side and cache side
   always_comb begin
      case (state)
         memCtrlPkg::evict1, memCtrlPkg::fill1:       memWord = 2'd1;
         memCtrlPkg::evict2, memCtrlPkg::fill2Write0: memWord = 2'd2;
         memCtrlPkg::evict3, memCtrlPkg::fill3Write1: memWord = 2'd3;
         default:                                     memWord = 2'd0;
      endcase
      case (state)
         memCtrlPkg::evict1, memCtrlPkg::fill3Write1: cacheWord = 2'd1;
         memCtrlPkg::evict2, memCtrlPkg::write2:      cacheWord = 2'd2;
         memCtrlPkg::evict3, memCtrlPkg::write3:      cacheWord = 2'd3;
         default:                                     cacheWord = 2'd0;
      endcase
   end

   // ############################
   // next state
   // ############################
   always_comb begin
      nextState = state;
      case (state)
         memCtrlPkg::idle: nextState = startState(rd, wr);
         memCtrlPkg::compRead, memCtrlPkg::compWrite: begin
            if (lookupHit) begin
               nextState = memCtrlPkg::hitDone;
            end else if (victimDirty) begin
               nextState = memCtrlPkg::evict0;
            end else begin
               nextState = memCtrlPkg::fill0;
            end
         end
         // memory states wait out a busy bank
         memCtrlPkg::evict0: if (!memStall) nextState = memCtrlPkg::evict1;
         memCtrlPkg::evict1: if (!memStall) nextState = memCtrlPkg::evict2;
         memCtrlPkg::evict2: if (!memStall) nextState = memCtrlPkg::evict3;
         memCtrlPkg::evict3: if (!memStall) nextState = memCtrlPkg::fill0;
         memCtrlPkg::fill0: if (!memStall) nextState = memCtrlPkg::fill1;
         memCtrlPkg::fill1: if (!memStall) nextState = memCtrlPkg::fill2Write0;
         memCtrlPkg::fill2Write0: if (!memStall) nextState = memCtrlPkg::fill3Write1;
         memCtrlPkg::fill3Write1: if (!memStall) nextState = memCtrlPkg::write2;
         memCtrlPkg::write2: nextState = memCtrlPkg::write3;
         // write miss still has its own word to store
         memCtrlPkg::write3: nextState = wr ? memCtrlPkg::finalWrite : memCtrlPkg::writeDone;
         memCtrlPkg::finalWrite: nextState = memCtrlPkg::writeDone;
         // back-to-back requests skip idle
         memCtrlPkg::writeDone, memCtrlPkg::hitDone: nextState = startState(rd, wr);
         default: nextState = memCtrlPkg::idle;
      endcase
   end

   // ############################
   // cache and memory commands
   // ############################
   always_comb begin
      // cache idles on the bank-only read states
      cacheCmd.enable  = (state != memCtrlPkg::fill0) && (state != memCtrlPkg::fill1);
      cacheCmd.compare = state inside {memCtrlPkg::compRead, memCtrlPkg::compWrite,
                                       memCtrlPkg::finalWrite};
      cacheCmd.write   = state inside {memCtrlPkg::compWrite, memCtrlPkg::finalWrite};
      cacheCmd.tag     = req.tag;
      cacheCmd.index   = req.index;
      cacheCmd.offset  = req.offset;
      cacheCmd.dataIn  = dataIn;

      memReq.rd   = 1'b0;
      memReq.wr   = 1'b0;
      memReq.addr = wordAddr(req.tag, req.index, memWord);
      memReq.data = dataIn;

      // victim words go out under the victim's own tag
      if (isEvict) begin
         cacheCmd.offset = {cacheWord, 1'b0};
         memReq.wr       = 1'b1;
         memReq.addr     = wordAddr(victimTag, req.index, memWord);
      end
      if (isFillRead) begin
         memReq.rd = 1'b1;
      end
      // fill words land clean under the request tag
      if (isFillWrite) begin
         cacheCmd.write  = 1'b1;
         cacheCmd.offset = {cacheWord, 1'b0};
         cacheCmd.dataIn = memData;
      end
   end

   // requester side
   assign stall        = ~isReady;
   assign done         = (state == memCtrlPkg::hitDone) || (state == memCtrlPkg::writeDone);
   assign cacheHit     = state == memCtrlPkg::hitDone;
   assign flipVictim   = done;
   // way choice is taken whenever a new request can be seen
   assign updateSelect = isReady;

endmodule

`default_nettype wire

// File: verilog/wayPolicy.sv
// wayPolicy: picks the way for each access, keeps the victim bit and muxes the way outputs
`timescale 1ns/1ns
`default_nettype none

module wayPolicy (
   input  wire logic                        clk,
   input  wire logic                        rstN,
   input  wire cacheGeometryPkg::wayStatusT way0,
   input  wire cacheGeometryPkg::wayStatusT way1,
   input  wire logic                        cmdWrite,
   input  wire logic                        updateSelect,
   input  wire logic                        flipVictim,
   output logic                             wayWrite0,
   output logic                             wayWrite1,
   output logic                             lookupHit,
   output logic                             victimDirty,
   output cacheGeometryPkg::tagT            victimTag,
   output cacheGeometryPkg::wordT           dataOut
);

   logic                        pickWay;
   logic                        selWay;
   logic                        victimBit;
   cacheGeometryPkg::wayStatusT chosen;

   // hit way first, then an invalid way (way0 first), then the victim
   always_comb begin
      if (way0.hit) begin
         pickWay = 1'b0;
      end else if (way1.hit) begin
         pickWay = 1'b1;
      end else if (!way0.valid) begin
         pickWay = 1'b0;
      end else if (!way1.valid) begin
         pickWay = 1'b1;
      end else begin
         // victim bit as the next access sees it after this cycle's flip
         pickWay = victimBit ^ flipVictim;
      end
   end

   // ############################
   // select and victim registers
   // ############################
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         selWay    <= 1'b0;
         victimBit <= 1'b0;
      end else begin
         // choice is held for the whole access
         if (updateSelect) begin
            selWay <= pickWay;
         end
         // flips once per finished access
         if (flipVictim) begin
            victimBit <= ~victimBit;
         end
      end
   end

   // only the held way sees the write
   assign wayWrite0 = cmdWrite & ~selWay;
   assign wayWrite1 = cmdWrite & selWay;

   assign lookupHit = way0.hit | way1.hit;

   // everything the controller and the requester read comes from the held way
   assign chosen      = selWay ? way1 : way0;
   assign victimDirty = chosen.dirty;
   assign victimTag   = chosen.tagOut;
   assign dataOut     = chosen.dataOut;

endmodule

`default_nettype wire
